// File: hw/peb_pkg.sv
package peb_pkg;

   // CPU request as seen by every card. TI numbering, bit 0 is the MSB.
   typedef struct packed {
      logic [0:15] a;
      logic [0:7]  d;
      logic        memen;
      logic        we;      // One-cycle write pulse.
      logic        dbin;
   } cpu_bus_t;

   typedef struct packed {
      logic [0:7] q;
      logic       q_select;
      logic       cruin;
      logic       cru_select;
      logic       ready;
   } card_resp_t;

   typedef struct packed {
      logic [0:13] adr;
      logic [0:7]  dat;
      logic        we;
      logic        stb;
      logic        cyc;
   } wb_req_t;

   typedef struct packed {
      logic [0:7] dat;
      logic       ack;
   } wb_resp_t;

   // Opcode sits in bits 0 to 2 of the command byte.
   typedef enum logic [2:0] {
      CMD_NONE      = 3'd0,
      CMD_RESTORE   = 3'd1,
      CMD_READ      = 3'd2,
      CMD_WRITE     = 3'd3,
      CMD_FORCE_INT = 3'd4
   } fdc_cmd_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HOST_WAIT,
      ST_CPU_XFER,
      ST_DONE
   } fdc_state_e;

   localparam logic [0:15] FDC_CRU_BASE = 16'h1100;
   localparam logic [0:15] FDC_REG_BASE = 16'h5ff0;  // 16-byte window.

   // Status bits, counted from the LSB.
   localparam int STAT_BUSY      = 0;
   localparam int STAT_DRQ       = 1;
   localparam int STAT_NOT_READY = 7;

endpackage

// File: hw/peb_ram32k.sv
module peb_ram32k (
   input  logic                clk,
   input  logic                arst_n_i,
   input  logic                enable_i,
   input  peb_pkg::cpu_bus_t   bus_i,
   output peb_pkg::card_resp_t resp_o
);

   logic [0:7]  mem [0:32767];
   logic [14:0] idx;
   logic        lo_win;
   logic        hi_win;
   logic        sel;
   logic        memen_q;
   logic        rd_start;
   logic [0:7]  q_r;

   assign lo_win = bus_i.a[0:2] == 3'b001;                  // 2000-3FFF.
   assign hi_win = bus_i.a[0] && (bus_i.a[1:2] != 2'b00);   // A000-FFFF.
   assign sel    = enable_i && (lo_win || hi_win);

   // Low window lands at 0000 of the array, high window at 2000.
   assign idx = hi_win ? bus_i.a[1:15] : {2'b00, bus_i.a[3:15]};

   always_ff @(posedge clk) begin
      if (sel && bus_i.memen && bus_i.we) begin
         mem[idx] <= bus_i.d;
      end
      q_r <= mem[idx];
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         memen_q <= 1'b0;
      end else begin
         memen_q <= bus_i.memen;
      end
   end

   // First cycle of a read is the wait state.
   assign rd_start = sel && bus_i.memen && bus_i.dbin && !memen_q;

   assign resp_o = '{
      q:          q_r,
      q_select:   sel && bus_i.memen,
      cruin:      1'b0,
      cru_select: 1'b0,
      ready:      !rd_start
   };

endmodule

// File: hw/peb_fdc_motor_timer.sv
module peb_fdc_motor_timer #(
   parameter int unsigned MOTOR_TICKS = 3_000_000
) (
   input  logic clk,
   input  logic arst_n_i,
   input  logic tick_i,
   input  logic restart_i,
   output logic running_o
);

   localparam int CNT_W = $clog2(MOTOR_TICKS + 1);

   logic [CNT_W-1:0] count;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count <= '0;
      end else if (restart_i) begin
         count <= CNT_W'(MOTOR_TICKS);
      end else if (tick_i && (count != '0)) begin
         count <= count - 1'b1;
      end
   end

   assign running_o = count != '0;

endmodule

// File: hw/peb_fdc_ctrl.sv
module peb_fdc_ctrl (
   input  logic                clk,
   input  logic                arst_n_i,
   input  peb_pkg::fdc_cmd_e   cmd_i,
   input  logic                cmd_valid_i,
   input  logic                host_done_i,
   input  logic                byte_last_i,
   output peb_pkg::fdc_state_e state_o,
   output peb_pkg::fdc_cmd_e   pending_o,
   output logic                busy_o,
   output logic                drq_o,
   output logic                clear_track_o,
   output logic                count_reset_o
);

   peb_pkg::fdc_state_e state;
   peb_pkg::fdc_state_e state_nxt;
   peb_pkg::fdc_cmd_e   op;           // Command in progress.
   peb_pkg::fdc_cmd_e   op_nxt;
   peb_pkg::fdc_cmd_e   pending;      // What the host is asked to do.
   peb_pkg::fdc_cmd_e   pending_nxt;

   always_comb begin
      state_nxt     = state;
      op_nxt        = op;
      pending_nxt   = pending;
      clear_track_o = 1'b0;
      count_reset_o = 1'b0;
      if (cmd_valid_i && (cmd_i == peb_pkg::CMD_FORCE_INT)) begin
         state_nxt   = peb_pkg::ST_IDLE;   // Abort from anywhere.
         op_nxt      = peb_pkg::CMD_NONE;
         pending_nxt = peb_pkg::CMD_NONE;
      end else begin
         case (state)
            peb_pkg::ST_IDLE: begin
               if (cmd_valid_i) begin
                  case (cmd_i)
                     peb_pkg::CMD_RESTORE: begin
                        clear_track_o = 1'b1;
                        state_nxt     = peb_pkg::ST_DONE;
                     end
                     peb_pkg::CMD_READ: begin
                        op_nxt      = peb_pkg::CMD_READ;
                        pending_nxt = peb_pkg::CMD_READ;
                        state_nxt   = peb_pkg::ST_HOST_WAIT;
                     end
                     peb_pkg::CMD_WRITE: begin
                        op_nxt        = peb_pkg::CMD_WRITE;
                        count_reset_o = 1'b1;
                        state_nxt     = peb_pkg::ST_CPU_XFER;
                     end
                     default: ;
                  endcase
               end
            end
            peb_pkg::ST_HOST_WAIT: begin
               if (host_done_i) begin
                  pending_nxt = peb_pkg::CMD_NONE;
                  if (op == peb_pkg::CMD_READ) begin
                     count_reset_o = 1'b1;    // Sector now in the buffer.
                     state_nxt     = peb_pkg::ST_CPU_XFER;
                  end else begin
                     state_nxt = peb_pkg::ST_DONE;
                  end
               end
            end
            peb_pkg::ST_CPU_XFER: begin
               if (byte_last_i) begin
                  if (op == peb_pkg::CMD_READ) begin
                     state_nxt = peb_pkg::ST_DONE;
                  end else begin
                     pending_nxt = peb_pkg::CMD_WRITE;
                     state_nxt   = peb_pkg::ST_HOST_WAIT;
                  end
               end
            end
            peb_pkg::ST_DONE: begin
               op_nxt    = peb_pkg::CMD_NONE;
               state_nxt = peb_pkg::ST_IDLE;
            end
            default: state_nxt = peb_pkg::ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state   <= peb_pkg::ST_IDLE;
         op      <= peb_pkg::CMD_NONE;
         pending <= peb_pkg::CMD_NONE;
      end else begin
         state   <= state_nxt;
         op      <= op_nxt;
         pending <= pending_nxt;
      end
   end

   assign state_o   = state;
   assign pending_o = pending;
   assign busy_o    = state != peb_pkg::ST_IDLE;
   assign drq_o     = state == peb_pkg::ST_CPU_XFER;

endmodule

// File: hw/peb_fdc_buffer.sv
module peb_fdc_buffer (
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       cpu_rd_i,
   input  logic       cpu_wr_i,
   input  logic [0:7] cpu_dat_i,
   output logic [0:7] cpu_dat_o,
   input  logic       count_reset_i,
   output logic       byte_last_o,
   input  logic [7:0] host_adr_i,
   input  logic       host_we_i,
   input  logic [0:7] host_dat_i,
   output logic [0:7] host_dat_o
);

   logic [0:7] mem [0:255];
   logic [7:0] count;    // CPU side byte pointer.

   always_ff @(posedge clk) begin
      if (cpu_wr_i) begin
         mem[count] <= cpu_dat_i;
      end
      if (host_we_i) begin
         mem[host_adr_i] <= host_dat_i;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count <= '0;
      end else if (count_reset_i) begin
         count <= '0;
      end else if (cpu_rd_i || cpu_wr_i) begin
         count <= count + 1'b1;   // Wraps after 255.
      end
   end

   assign cpu_dat_o   = mem[count];
   assign host_dat_o  = mem[host_adr_i];
   assign byte_last_o = (count == 8'hff) && (cpu_rd_i || cpu_wr_i);

endmodule

// File: hw/peb_fdc.sv
module peb_fdc #(
   parameter int unsigned MOTOR_TICKS = 3_000_000
) (
   input  logic                clk,
   input  logic                arst_n_i,
   input  logic                cpu_clk_en_i,
   input  logic                enable_i,
   input  peb_pkg::cpu_bus_t   bus_i,
   input  logic                cruclk_i,
   output peb_pkg::card_resp_t resp_o,
   output logic [1:3]          drive_activity_o,
   input  peb_pkg::wb_req_t    wb_i,
   output peb_pkg::wb_resp_t   wb_o
);

   logic [0:10]         cru_num;
   logic                cru_select;
   logic                cru_wr;
   logic                cruin;
   logic [7:0]          cru_bits;
   logic                motor_restart;
   logic                motor_running;
   logic                win_sel;
   logic [0:3]          reg_off;
   logic                memen_q;
   logic                cpu_wr;
   logic                data_rd;
   logic                cmd_valid;
   logic [0:7]          track;
   logic [0:7]          sector;
   logic [0:7]          data_hold;
   logic [7:0]          status;
   logic [0:7]          cpu_q;
   peb_pkg::fdc_state_e state;
   peb_pkg::fdc_cmd_e   pending;
   logic                busy;
   logic                drq;
   logic                clear_track;
   logic                count_reset;
   logic                xfer;
   logic [0:7]          buf_cpu_dat;
   logic [0:7]          buf_host_dat;
   logic                byte_last;
   logic                wb_new;
   logic                host_buf;
   logic                host_we;
   logic                host_done;
   logic [0:7]          host_q;
   logic                ack_q;

   // CRU bit number within the card.
   assign cru_num    = bus_i.a[4:14] - peb_pkg::FDC_CRU_BASE[4:14];
   assign cru_select = enable_i && (bus_i.a[0:7] == peb_pkg::FDC_CRU_BASE[0:7]);
   assign cru_wr     = cru_select && cruclk_i && (cru_num[0:7] == '0);
   assign cruin      = (cru_num[0:7] == '0) ? cru_bits[cru_num[8:10]] : 1'b0;
   assign motor_restart = cru_wr && (cru_num[8:10] == 3'd1) && bus_i.a[15];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cru_bits <= '0;
      end else if (cru_wr) begin
         cru_bits[cru_num[8:10]] <= bus_i.a[15];
      end
   end

   assign drive_activity_o = {cru_bits[4], cru_bits[5], cru_bits[6]} & {3{motor_running}};

   // Register window needs CRU bit 0.
   assign win_sel = enable_i && cru_bits[0] &&
                    (bus_i.a[0:11] == peb_pkg::FDC_REG_BASE[0:11]);
   assign reg_off = bus_i.a[12:15];
   assign cpu_wr  = win_sel && bus_i.memen && bus_i.we;
   assign data_rd = win_sel && bus_i.memen && bus_i.dbin && !memen_q && (reg_off == 4'h6);
   assign cmd_valid = cpu_wr && (reg_off == 4'h8);
   assign xfer      = state == peb_pkg::ST_CPU_XFER;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         memen_q <= 1'b0;
         track   <= '0;
         sector  <= '0;
      end else begin
         memen_q <= bus_i.memen;
         if (clear_track) begin
            track <= '0;
         end else if (cpu_wr && (reg_off == 4'ha)) begin
            track <= bus_i.d;
         end
         if (cpu_wr && (reg_off == 4'hc)) begin
            sector <= bus_i.d;
         end
      end
   end

   // Keeps the data byte stable while memen stays high.
   always_ff @(posedge clk) begin
      if (data_rd) begin
         data_hold <= buf_cpu_dat;
      end
   end

   always_comb begin
      status                          = '0;
      status[peb_pkg::STAT_BUSY]      = busy;
      status[peb_pkg::STAT_DRQ]       = drq;
      status[peb_pkg::STAT_NOT_READY] = !motor_running;
   end

   always_comb begin
      case (reg_off)
         4'h0: cpu_q = status;
         4'h2: cpu_q = track;
         4'h4: cpu_q = sector;
         4'h6: cpu_q = memen_q ? data_hold : buf_cpu_dat;
         default: cpu_q = 8'hff;
      endcase
   end

   assign resp_o = '{
      q:          cpu_q,
      q_select:   win_sel && bus_i.memen,
      cruin:      cruin,
      cru_select: cru_select,
      ready:      1'b1
   };

   // Host side; one action per Wishbone transfer.
   assign wb_new    = wb_i.stb && wb_i.cyc && !ack_q;
   assign host_buf  = wb_i.adr[0:5] == '0;
   assign host_we   = wb_new && wb_i.we && host_buf;
   assign host_done = wb_new && wb_i.we && (wb_i.adr == 14'd259);

   always_comb begin
      if (host_buf) begin
         host_q = buf_host_dat;
      end else begin
         case (wb_i.adr)
            14'd256: host_q = {5'b00000, pending};
            14'd257: host_q = track;
            14'd258: host_q = sector;
            default: host_q = 8'h00;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= wb_new;
      end
   end

   assign wb_o = '{dat: host_q, ack: ack_q};

   peb_fdc_ctrl i_ctrl (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .cmd_i         (peb_pkg::fdc_cmd_e'(bus_i.d[0:2])),
      .cmd_valid_i   (cmd_valid),
      .host_done_i   (host_done),
      .byte_last_i   (byte_last),
      .state_o       (state),
      .pending_o     (pending),
      .busy_o        (busy),
      .drq_o         (drq),
      .clear_track_o (clear_track),
      .count_reset_o (count_reset)
   );

   peb_fdc_buffer i_buffer (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .cpu_rd_i      (data_rd && xfer),
      .cpu_wr_i      (cpu_wr && (reg_off == 4'he) && xfer),
      .cpu_dat_i     (bus_i.d),
      .cpu_dat_o     (buf_cpu_dat),
      .count_reset_i (count_reset),
      .byte_last_o   (byte_last),
      .host_adr_i    (wb_i.adr[6:13]),
      .host_we_i     (host_we),
      .host_dat_i    (wb_i.dat),
      .host_dat_o    (buf_host_dat)
   );

   peb_fdc_motor_timer #(
      .MOTOR_TICKS (MOTOR_TICKS)
   ) i_motor (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .tick_i    (cpu_clk_en_i),
      .restart_i (motor_restart),
      .running_o (motor_running)
   );

endmodule

// File: hw/peb.sv
module peb #(
   parameter int unsigned MOTOR_TICKS = 3_000_000
) (
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic        cpu_clk_en_i,
   input  logic        enable_ram32k_i,
   input  logic        enable_fdc_i,
   input  logic [0:15] a_i,
   input  logic [0:7]  d_i,
   input  logic        memen_i,
   input  logic        dbin_i,
   input  logic        we_i,
   input  logic        cruclk_i,
   output logic [0:7]  q_o,
   output logic        cruin_o,
   output logic        ready_o,
   output logic [1:3]  drive_activity_o,
   input  logic [0:22] wb_adr_i,
   input  logic [0:7]  wb_dat_i,
   input  logic        wb_we_i,
   input  logic [0:0]  wb_sel_i,
   input  logic        wb_stb_i,
   input  logic        wb_cyc_i,
   output logic [0:7]  wb_dat_o,
   output logic        wb_ack_o
);

   peb_pkg::cpu_bus_t   bus;
   peb_pkg::card_resp_t resp_ram;
   peb_pkg::card_resp_t resp_fdc;
   peb_pkg::wb_req_t    wb_fdc_req;
   peb_pkg::wb_resp_t   wb_fdc_resp;
   logic                wb_fdc_sel;

   assign bus = '{a: a_i, d: d_i, memen: memen_i, we: we_i, dbin: dbin_i};

   // Unselected cards float high on the data bus.
   assign q_o = (resp_ram.q_select ? resp_ram.q : 8'hff) &
                (resp_fdc.q_select ? resp_fdc.q : 8'hff);
   assign cruin_o = (resp_ram.cru_select && resp_ram.cruin) ||
                    (resp_fdc.cru_select && resp_fdc.cruin);
   assign ready_o = resp_ram.ready && resp_fdc.ready;

   assign wb_fdc_sel = (wb_adr_i[0:2] == 3'h0) && (wb_adr_i[3:6] == 4'h0);

   assign wb_fdc_req = '{
      adr: wb_adr_i[9:22],
      dat: wb_dat_i,
      we:  wb_we_i && wb_sel_i[0],     // No lane, no write.
      stb: wb_stb_i && wb_fdc_sel,
      cyc: wb_cyc_i && wb_fdc_sel
   };

   assign wb_dat_o = wb_fdc_sel ? wb_fdc_resp.dat : 8'h00;
   assign wb_ack_o = wb_fdc_sel && wb_fdc_resp.ack;

   peb_ram32k i_ram32k (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .enable_i (enable_ram32k_i),
      .bus_i    (bus),
      .resp_o   (resp_ram)
   );

   peb_fdc #(
      .MOTOR_TICKS (MOTOR_TICKS)
   ) i_fdc (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .cpu_clk_en_i     (cpu_clk_en_i),
      .enable_i         (enable_fdc_i),
      .bus_i            (bus),
      .cruclk_i         (cruclk_i),
      .resp_o           (resp_fdc),
      .drive_activity_o (drive_activity_o),
      .wb_i             (wb_fdc_req),
      .wb_o             (wb_fdc_resp)
   );

endmodule

// File: sim/tb_peb.sv
module tb_peb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int unsigned MOTOR_TICKS = 40;
   localparam int          CLK_PERIOD  = 8;
   localparam logic [31:0] SEED        = 32'hf2983c8b;
   localparam int          WAIT_LIMIT  = 16;      // Cycles allowed for ready or ack.
   localparam int          DARK_TICKS  = 45;

   // Cycle budget of each test, summed by the watchdog.
   localparam int RAM_CYCLES     = 200;
   localparam int CRU_CYCLES     = 100 + DARK_TICKS * 4;
   localparam int SECTOR_CYCLES  = 256 * 4 + 256 * 4 + 100;
   localparam int RESTORE_CYCLES = 100;
   localparam int BUDGET_CYCLES  = 8 + RAM_CYCLES + CRU_CYCLES + 2 * SECTOR_CYCLES +
                                   RESTORE_CYCLES + 1000;

   localparam logic [15:0] REG_STATUS    = 16'h5ff0;
   localparam logic [15:0] REG_TRACK_RD  = 16'h5ff2;
   localparam logic [15:0] REG_SECTOR_RD = 16'h5ff4;
   localparam logic [15:0] REG_DATA_RD   = 16'h5ff6;
   localparam logic [15:0] REG_CMD       = 16'h5ff8;
   localparam logic [15:0] REG_TRACK_WR  = 16'h5ffa;
   localparam logic [15:0] REG_SECTOR_WR = 16'h5ffc;
   localparam logic [15:0] REG_DATA_WR   = 16'h5ffe;

   localparam logic [7:0][15:0] RAM_ADDRS = {16'h2000, 16'h2abc, 16'h3fff, 16'ha000,
                                             16'hb5a5, 16'hc123, 16'he800, 16'hffff};

   logic        clk;
   logic        arst_n;
   logic        cpu_clk_en;
   logic        enable_ram32k;
   logic        enable_fdc;
   logic [0:15] a;
   logic [0:7]  d;
   logic        memen;
   logic        dbin;
   logic        we;
   logic        cruclk;
   logic [0:7]  q;
   logic        cruin;
   logic        ready;
   logic [1:3]  drive_activity;
   logic [0:22] wb_adr;
   logic [0:7]  wb_dat_in;
   logic        wb_we;
   logic [0:0]  wb_sel;
   logic        wb_stb;
   logic        wb_cyc;
   logic [0:7]  wb_dat_out;
   logic        wb_ack;

   int          errors;
   int          tick_phase;
   int          read_waits;   // Clock edges of the last CPU read with ready low.
   logic [31:0] rng;

   peb #(
      .MOTOR_TICKS (MOTOR_TICKS)
   ) i_peb (
      .clk              (clk),
      .arst_n_i         (arst_n),
      .cpu_clk_en_i     (cpu_clk_en),
      .enable_ram32k_i  (enable_ram32k),
      .enable_fdc_i     (enable_fdc),
      .a_i              (a),
      .d_i              (d),
      .memen_i          (memen),
      .dbin_i           (dbin),
      .we_i             (we),
      .cruclk_i         (cruclk),
      .q_o              (q),
      .cruin_o          (cruin),
      .ready_o          (ready),
      .drive_activity_o (drive_activity),
      .wb_adr_i         (wb_adr),
      .wb_dat_i         (wb_dat_in),
      .wb_we_i          (wb_we),
      .wb_sel_i         (wb_sel),
      .wb_stb_i         (wb_stb),
      .wb_cyc_i         (wb_cyc),
      .wb_dat_o         (wb_dat_out),
      .wb_ack_o         (wb_ack)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Clock enable, high one cycle in four.
   initial begin
      cpu_clk_en = 1'b0;
      tick_phase = 0;
      forever begin
         @(posedge clk);
         #1;
         tick_phase = (tick_phase + 1) % 4;
         cpu_clk_en = tick_phase == 0;
      end
   end

   initial begin
      #(BUDGET_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d clock cycles, tests did not finish", BUDGET_CYCLES);
      $display("Errors: %0d", errors + 1);
      $display("Simulation finished: FAIL");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [7:0] cmd_byte(input logic [2:0] op);
      return {op, 5'b00000};    // Opcode in TI bits 0 to 2.
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("Fail %s: expected %0h, got %0h", name, expected, actual);
      end
   endtask

   task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
      a     = addr;
      d     = data;
      memen = 1'b1;
      we    = 1'b1;
      @(posedge clk);
      #1;
      memen = 1'b0;
      we    = 1'b0;
      @(posedge clk);     // memen low for one edge between accesses.
      #1;
   endtask

   task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
      int waits;
      a     = addr;
      memen = 1'b1;
      dbin  = 1'b1;
      waits = 0;
      @(negedge clk);
      if (!ready) begin
         waits++;         // Wait state before the first edge.
      end
      @(posedge clk);
      #1;
      while (!ready && waits < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         waits++;
      end
      if (!ready) begin
         errors++;
         $display("CPU read at %h never got ready back", addr);
      end
      read_waits = waits;
      data  = q;
      memen = 1'b0;
      dbin  = 1'b0;
      @(posedge clk);
      #1;
   endtask

   task automatic cru_write(input int bit_num, input logic value);
      a      = peb_pkg::FDC_CRU_BASE + 16'(2 * bit_num) + 16'(value);
      cruclk = 1'b1;
      @(posedge clk);
      #1;
      cruclk = 1'b0;
   endtask

   task automatic cru_read(input int bit_num, output logic value);
      a = peb_pkg::FDC_CRU_BASE + 16'(2 * bit_num);
      @(posedge clk);
      #1;
      value = cruin;
   endtask

   task automatic wb_write(input int offset, input logic [7:0] data);
      int waits;
      wb_adr    = 23'(offset);
      wb_dat_in = data;
      wb_we     = 1'b1;
      wb_stb    = 1'b1;
      wb_cyc    = 1'b1;
      waits     = 0;
      do begin
         @(posedge clk);
         #1;
         waits++;
      end while (!wb_ack && waits < WAIT_LIMIT);
      if (!wb_ack) begin
         errors++;
         $display("Wishbone write to offset %0d was never acknowledged", offset);
      end
      wb_we  = 1'b0;
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
   endtask

   task automatic wb_read(input int offset, output logic [7:0] data);
      int waits;
      wb_adr = 23'(offset);
      wb_we  = 1'b0;
      wb_stb = 1'b1;
      wb_cyc = 1'b1;
      waits  = 0;
      do begin
         @(posedge clk);
         #1;
         waits++;
      end while (!wb_ack && waits < WAIT_LIMIT);
      if (!wb_ack) begin
         errors++;
         $display("Wishbone read from offset %0d was never acknowledged", offset);
      end
      data   = wb_dat_out;
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
   endtask

   task automatic ram_windows();
      logic [7:0] pattern [8];
      logic [7:0] rd;
      for (int i = 0; i < 8; i++) begin
         rng        = xorshift(rng);
         pattern[i] = rng[7:0];
         cpu_write(RAM_ADDRS[i], pattern[i]);
      end
      for (int i = 0; i < 8; i++) begin
         cpu_read(RAM_ADDRS[i], rd);
         check($sformatf("q_o at %h", RAM_ADDRS[i]), pattern[i], rd);
         check("ready_o wait cycles", 1, read_waits);    // One RAM wait state.
      end
      cpu_read(16'h8300, rd);
      check("q_o at 8300", 8'hff, rd);
      check("ready_o wait cycles at 8300", 0, read_waits);
      enable_ram32k = 1'b0;
      cpu_read(RAM_ADDRS[0], rd);
      check("q_o with RAM disabled", 8'hff, rd);
      enable_ram32k = 1'b1;
   endtask

   task automatic reset_and_cru();
      logic [7:0] rd;
      logic       bit_val;
      logic       acked;
      int         cycles;
      check("ready_o", 1'b1, ready);
      check("drive_activity_o", 3'b000, drive_activity);
      check("wb_ack_o", 1'b0, wb_ack);
      cru_read(0, bit_val);
      check("cruin_o bit 0 after reset", 1'b0, bit_val);
      cru_write(0, 1'b1);      // Opens the register window.
      cpu_read(REG_STATUS, rd);
      check("status after reset", 8'h80, rd);
      cru_write(4, 1'b1);
      cru_write(1, 1'b1);
      check("drive_activity_o", 3'b100, drive_activity);
      cycles = 0;
      while (drive_activity != 3'b000 && cycles < DARK_TICKS * 4) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      check("drive_activity_o after motor timeout", 3'b000, drive_activity);
      if (cycles < 36 * 4) begin
         errors++;
         $display("Drive activity went dark after only %0d cycles", cycles);
      end
      cru_read(0, bit_val);
      check("cruin_o bit 0", 1'b1, bit_val);
      cru_read(2, bit_val);
      check("cruin_o bit 2", 1'b0, bit_val);
      // Outside the disk controller range nothing answers.
      wb_adr = 23'h400000;
      wb_stb = 1'b1;
      wb_cyc = 1'b1;
      acked  = 1'b0;
      repeat (4) begin
         @(posedge clk);
         #1;
         acked = acked | wb_ack;
      end
      check("wb_dat_o outside range", 8'h00, wb_dat_out);
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      check("wb_ack_o outside range", 1'b0, acked);
   endtask

   task automatic read_sector();
      logic [7:0] sector_data [256];
      logic [7:0] rd;
      cpu_write(REG_TRACK_WR, 8'h27);
      cpu_write(REG_SECTOR_WR, 8'h05);
      cpu_write(REG_CMD, cmd_byte(peb_pkg::CMD_READ));
      cpu_read(REG_STATUS, rd);
      check("status busy", 1'b1, rd[peb_pkg::STAT_BUSY]);
      wb_read(256, rd);
      check("pending opcode", peb_pkg::CMD_READ, rd);
      wb_read(257, rd);
      check("host track", 8'h27, rd);
      wb_read(258, rd);
      check("host sector", 8'h05, rd);
      for (int i = 0; i < 256; i++) begin
         rng            = xorshift(rng);
         sector_data[i] = rng[7:0];
         wb_write(i, sector_data[i]);
      end
      wb_write(259, 8'h00);
      cpu_read(REG_STATUS, rd);
      check("status drq", 1'b1, rd[peb_pkg::STAT_DRQ]);
      wb_read(256, rd);
      check("pending opcode after done", peb_pkg::CMD_NONE, rd);
      for (int i = 0; i < 256; i++) begin
         cpu_read(REG_DATA_RD, rd);
         check($sformatf("data byte %0d", i), sector_data[i], rd);
      end
      cpu_read(REG_STATUS, rd);
      check("status busy", 1'b0, rd[peb_pkg::STAT_BUSY]);
      check("status drq", 1'b0, rd[peb_pkg::STAT_DRQ]);
   endtask

   task automatic write_sector();
      logic [7:0] sector_data [256];
      logic [7:0] rd;
      cpu_write(REG_CMD, cmd_byte(peb_pkg::CMD_WRITE));
      cpu_read(REG_STATUS, rd);
      check("status drq", 1'b1, rd[peb_pkg::STAT_DRQ]);
      for (int i = 0; i < 256; i++) begin
         rng            = xorshift(rng);
         sector_data[i] = rng[7:0];
         cpu_write(REG_DATA_WR, sector_data[i]);
      end
      wb_read(256, rd);
      check("pending opcode", peb_pkg::CMD_WRITE, rd);
      cpu_read(REG_STATUS, rd);
      check("status busy", 1'b1, rd[peb_pkg::STAT_BUSY]);
      check("status drq", 1'b0, rd[peb_pkg::STAT_DRQ]);
      for (int i = 0; i < 256; i++) begin
         wb_read(i, rd);
         check($sformatf("host buffer byte %0d", i), sector_data[i], rd);
      end
      wb_write(259, 8'h00);
      cpu_read(REG_STATUS, rd);
      check("status busy", 1'b0, rd[peb_pkg::STAT_BUSY]);
      wb_read(256, rd);
      check("pending opcode after done", peb_pkg::CMD_NONE, rd);
   endtask

   task automatic restore_and_abort();
      logic [7:0] rd;
      cpu_write(REG_TRACK_WR, 8'h33);
      cpu_read(REG_TRACK_RD, rd);
      check("track", 8'h33, rd);
      check("ready_o wait cycles on register read", 0, read_waits);
      cpu_write(REG_CMD, cmd_byte(peb_pkg::CMD_RESTORE));
      cpu_read(REG_TRACK_RD, rd);
      check("track after restore", 8'h00, rd);
      cpu_read(REG_STATUS, rd);
      check("status busy", 1'b0, rd[peb_pkg::STAT_BUSY]);
      cpu_write(REG_CMD, cmd_byte(peb_pkg::CMD_READ));
      wb_read(256, rd);
      check("pending opcode", peb_pkg::CMD_READ, rd);
      cpu_write(REG_CMD, cmd_byte(peb_pkg::CMD_FORCE_INT));
      cpu_read(REG_STATUS, rd);
      check("status busy", 1'b0, rd[peb_pkg::STAT_BUSY]);
      wb_read(256, rd);
      check("pending opcode after abort", peb_pkg::CMD_NONE, rd);
   endtask

   initial begin
      errors        = 0;
      read_waits    = 0;
      rng           = SEED;
      arst_n        = 1'b0;
      enable_ram32k = 1'b1;
      enable_fdc    = 1'b1;
      a             = '0;
      d             = '0;
      memen         = 1'b0;
      dbin          = 1'b0;
      we            = 1'b0;
      cruclk        = 1'b0;
      wb_adr        = '0;
      wb_dat_in     = '0;
      wb_we         = 1'b0;
      wb_sel        = 1'b1;
      wb_stb        = 1'b0;
      wb_cyc        = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;

      reset_and_cru();
      ram_windows();
      read_sector();
      write_sector();
      restore_and_abort();

      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: sim.f
hw/peb_pkg.sv
hw/peb_ram32k.sv
hw/peb_fdc_motor_timer.sv
hw/peb_fdc_ctrl.sv
hw/peb_fdc_buffer.sv
hw/peb_fdc.sv
hw/peb.sv
sim/tb_peb.sv

// File: Bender.yml
package:
  name: peb

sources:
  - hw/peb_pkg.sv
  - hw/peb_ram32k.sv
  - hw/peb_fdc_motor_timer.sv
  - hw/peb_fdc_ctrl.sv
  - hw/peb_fdc_buffer.sv
  - hw/peb_fdc.sv
  - hw/peb.sv
  - target: simulation
    files:
      - sim/tb_peb.sv
